//--- verilog/prng_pkg.sv
package prng_pkg;

  // Width of the LFSR state and of each wipe share.
  localparam int unsigned PrngWidth = 64;

  // The widest entropy beat that the reseed port carries.
  localparam int unsigned EntropyMaxWidth = 32;

  // The two shares of clearing data handed to the consumer.
  typedef struct packed {
    logic [PrngWidth-1:0] share0;
    logic [PrngWidth-1:0] share1;
  } clearing_data_t;

  // One entropy beat. A beat narrower than 32 bits sits in the low bits of data.
  typedef struct packed {
    logic                       ack;
    logic [EntropyMaxWidth-1:0] data;
  } entropy_rsp_t;

  // The seed word is filled in halves by the packer and read whole by the LFSR.
  typedef union packed {
    logic [PrngWidth-1:0]                full;
    logic [1:0][EntropyMaxWidth-1:0]     half;
  } seed_word_u;

  // Reset value of the LFSR state. It must not be zero.
  localparam logic [PrngWidth-1:0] LfsrSeedDefault = 64'h5A3C_96E1_0F87_C2B4;

  // Galois taps for x^64 + x^63 + x^61 + x^60 + 1 with a right-shifting register.
  localparam logic [PrngWidth-1:0] LfsrTaps = 64'hD800_0000_0000_0000;

  // The 4-bit PRINCE S-box.
  function automatic logic [3:0] prince_sbox(input logic [3:0] nibble);
    logic [3:0] res;
    case (nibble)
      4'h0: res = 4'hB;
      4'h1: res = 4'hF;
      4'h2: res = 4'h3;
      4'h3: res = 4'h2;
      4'h4: res = 4'hA;
      4'h5: res = 4'hC;
      4'h6: res = 4'h9;
      4'h7: res = 4'h1;
      4'h8: res = 4'h6;
      4'h9: res = 4'h7;
      4'hA: res = 4'h8;
      4'hB: res = 4'h0;
      4'hC: res = 4'hE;
      4'hD: res = 4'h5;
      4'hE: res = 4'hD;
      4'hF: res = 4'h4;
    endcase
    return res;
  endfunction

  // Output bit i takes input bit (9*i) mod 64. Nine is odd, so every bit is used once.
  function automatic logic [PrngWidth-1:0] state_perm(input logic [PrngWidth-1:0] in_word);
    logic [PrngWidth-1:0] out_word;
    for (int i = 0; i < PrngWidth; i++) begin
      out_word[i] = in_word[(9 * i) % PrngWidth];
    end
    return out_word;
  endfunction

  // Output bit i takes input bit (25*i+7) mod 64.
  function automatic logic [PrngWidth-1:0] share_perm(input logic [PrngWidth-1:0] in_word);
    logic [PrngWidth-1:0] out_word;
    for (int i = 0; i < PrngWidth; i++) begin
      out_word[i] = in_word[(25 * i + 7) % PrngWidth];
    end
    return out_word;
  endfunction

endpackage

//--- verilog/prng_ctrl.sv
`timescale 1ns/1ps

module prng_ctrl #(
  parameter bit SkipReseed = 1'b0
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   data_req_i,
  input  logic                   reseed_req_i,
  input  prng_pkg::entropy_rsp_t entropy_i,
  input  logic                   seed_done_i,
  output logic                   data_ack_o,
  output logic                   reseed_ack_o,
  output logic                   entropy_req_o,
  output logic                   beat_o,
  output logic                   lfsr_step_o,
  output logic                   seed_load_o
);

  // Reseeding has priority over data. While a reseed is pending the consumer
  // sees no acknowledge and the LFSR state stays put.
  assign data_ack_o = reseed_req_i ? 1'b0 : data_req_i;

  // Every acknowledged data cycle consumes the current value,
  // so the LFSR advances at the following edge.
  assign lfsr_step_o = data_ack_o;

  // Entropy is requested for as long as the reseed request is up.
  // With reseeding disabled the entropy port is never used.
  assign entropy_req_o = SkipReseed ? 1'b0 : reseed_req_i;

  // A beat is any cycle in which the request is high and the source answers.
  // A low ack simply stalls the packer.
  assign beat_o = entropy_req_o & entropy_i.ack;

  // The packer flags the beat that completes the seed word. That word is
  // loaded into the LFSR at the same edge.
  assign seed_load_o = SkipReseed ? 1'b0 : (beat_o & seed_done_i);

  // The reseed ends with the load. When reseeding is skipped the request
  // is answered straight away and the state is left alone.
  assign reseed_ack_o = SkipReseed ? reseed_req_i : seed_load_o;

  // A step and a load in one cycle would mean the priority logic failed.
  step_load_excl_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(lfsr_step_o && seed_load_o)
  ) else $error("LFSR step and seed load asserted together.");

  // With reseeding off no entropy may ever be requested.
  skip_no_entropy_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    SkipReseed |-> !entropy_req_o
  ) else $error("Entropy requested although reseeding is skipped.");

endmodule

//--- verilog/entropy_packer.sv
`timescale 1ns/1ps

module entropy_packer #(
  parameter int unsigned EntropyWidth = 32
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   beat_i,
  input  prng_pkg::entropy_rsp_t entropy_i,
  output prng_pkg::seed_word_u   seed_o,
  output logic                   seed_done_o
);

  import prng_pkg::*;

  // Number of beats that make up one seed word.
  localparam int unsigned NumBeats = PrngWidth / EntropyWidth;
  localparam int unsigned CntWidth = (NumBeats > 1) ? $clog2(NumBeats) : 1;
  localparam logic [CntWidth-1:0] LastBeat = CntWidth'(NumBeats - 1);

  logic [CntWidth-1:0] cnt_q;
  seed_word_u          seed_d;
  seed_word_u          seed_q;

  // Place the current beat into the word. The output already includes the
  // beat of this cycle so that the final beat can be loaded without delay.
  if (EntropyWidth == EntropyMaxWidth) begin : gen_halves
    // Two beats, each fills one half of the union.
    always_comb begin
      seed_d = seed_q;
      if (beat_i) begin
        seed_d.half[cnt_q[0]] = entropy_i.data;
      end
    end
  end else begin : gen_slices
    // Narrow beats go into slices of the full word, lowest beat first.
    // Only the low bits of the beat carry data.
    always_comb begin
      seed_d = seed_q;
      if (beat_i) begin
        seed_d.full[cnt_q*EntropyWidth +: EntropyWidth] = entropy_i.data[EntropyWidth-1:0];
      end
    end
  end

  // The beat counter wraps after the last beat, ready for the next reseed.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (beat_i) begin
      if (cnt_q == LastBeat) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // Collected beats wait here until the word is complete.
  always_ff @(posedge clk_i) begin
    if (beat_i) begin
      seed_q <= seed_d;
    end
  end

  assign seed_o      = seed_d;
  assign seed_done_o = beat_i && (cnt_q == LastBeat);

  // The beats have to tile the seed word exactly, and no beat is wider
  // than the entropy data field.
  width_ok_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ((PrngWidth % EntropyWidth) == 0) && (EntropyWidth <= EntropyMaxWidth)
  ) else $error("Unsupported entropy width %0d.", EntropyWidth);

endmodule

//--- verilog/clearing_lfsr.sv
`timescale 1ns/1ps

module clearing_lfsr #(
  parameter logic [prng_pkg::PrngWidth-1:0] LfsrSeed = prng_pkg::LfsrSeedDefault
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           step_i,
  input  logic                           load_i,
  input  prng_pkg::seed_word_u           seed_i,
  output logic [prng_pkg::PrngWidth-1:0] state_o
);

  import prng_pkg::*;

  logic [PrngWidth-1:0] state_d;
  logic [PrngWidth-1:0] state_q;
  logic [PrngWidth-1:0] feedback;

  // The bit shifted out at the bottom decides whether the taps are applied.
  assign feedback = state_q[0] ? LfsrTaps : '0;

  // Next state. A load and a step never come together, the load is checked
  // first anyway.
  always_comb begin
    state_d = state_q;
    if (load_i) begin
      state_d = seed_i.full;
    end else if (step_i) begin
      // One Galois step, shift right and fold in the taps.
      state_d = (state_q >> 1) ^ feedback;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= LfsrSeed;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

  // The all-zero state is a lock-up point of the LFSR. It can only be reached
  // through a bad reset seed or an all-zero entropy word.
  state_nonzero_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    state_q != '0
  ) else $error("LFSR state is zero.");

endmodule

//--- verilog/share_mixer.sv
`timescale 1ns/1ps

module share_mixer (
  input  logic [prng_pkg::PrngWidth-1:0] state_i,
  output prng_pkg::clearing_data_t       data_o
);

  import prng_pkg::*;

  // Number of 4-bit S-box lanes across the word.
  localparam int unsigned NumNibbles = PrngWidth / 4;

  logic [PrngWidth-1:0] perm_in;
  logic [PrngWidth-1:0] sbox_out;
  logic [PrngWidth-1:0] share0;
  logic [PrngWidth-1:0] share1;

  // First permutation spreads neighbouring LFSR bits over different nibbles,
  // so that each S-box sees bits from far apart in the state.
  assign perm_in = state_perm(state_i);

  // Non-linear layer. Every nibble goes through its own PRINCE S-box.
  for (genvar n = 0; n < NumNibbles; n++) begin : gen_sbox
    assign sbox_out[4*n +: 4] = prince_sbox(perm_in[4*n +: 4]);
  end

  // Second permutation mixes the S-box outputs back across the word.
  assign share0 = state_perm(sbox_out);

  // The second share is a fixed reordering of the first one. It is used to
  // clear the other share of masked registers.
  assign share1 = share_perm(share0);

  assign data_o.share0 = share0;
  assign data_o.share1 = share1;

endmodule

//--- verilog/prng_clearing_top.sv
`timescale 1ns/1ps

module prng_clearing_top #(
  parameter int unsigned                    EntropyWidth = 32,
  parameter bit                             SkipReseed   = 1'b0,
  parameter logic [prng_pkg::PrngWidth-1:0] LfsrSeed     = prng_pkg::LfsrSeedDefault
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // Consumer side.
  input  logic                     data_req_i,
  output logic                     data_ack_o,
  output prng_pkg::clearing_data_t data_o,
  input  logic                     reseed_req_i,
  output logic                     reseed_ack_o,

  // Entropy source for reseeding.
  output logic                     entropy_req_o,
  input  prng_pkg::entropy_rsp_t   entropy_i
);

  import prng_pkg::*;

  logic                 beat;
  logic                 seed_done;
  logic                 lfsr_step;
  logic                 seed_load;
  seed_word_u           seed;
  logic [PrngWidth-1:0] lfsr_state;

  // Arbitration and handshakes.
  prng_ctrl #(
    .SkipReseed (SkipReseed)
  ) u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .data_req_i    (data_req_i),
    .reseed_req_i  (reseed_req_i),
    .entropy_i     (entropy_i),
    .seed_done_i   (seed_done),
    .data_ack_o    (data_ack_o),
    .reseed_ack_o  (reseed_ack_o),
    .entropy_req_o (entropy_req_o),
    .beat_o        (beat),
    .lfsr_step_o   (lfsr_step),
    .seed_load_o   (seed_load)
  );

  // Builds the new seed from entropy beats.
  entropy_packer #(
    .EntropyWidth (EntropyWidth)
  ) u_packer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .beat_i      (beat),
    .entropy_i   (entropy_i),
    .seed_o      (seed),
    .seed_done_o (seed_done)
  );

  clearing_lfsr #(
    .LfsrSeed (LfsrSeed)
  ) u_lfsr (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .step_i  (lfsr_step),
    .load_i  (seed_load),
    .seed_i  (seed),
    .state_o (lfsr_state)
  );

  // Output shares follow the state without a register stage.
  share_mixer u_mixer (
    .state_i (lfsr_state),
    .data_o  (data_o)
  );

endmodule

//--- verification/prng_clearing_tb.sv
`timescale 1ns/1ps

module prng_clearing_tb;

  import prng_pkg::*;

  // The DUT runs with its default parameters, so every reseed takes two 32-bit beats.
  localparam int unsigned BeatWidth = 32;
  localparam int unsigned NumBeats  = PrngWidth / BeatWidth;
  localparam int unsigned NumRows   = 20;

  // Operations that a table row can apply.
  localparam logic [1:0] OpIdle   = 2'd0;
  localparam logic [1:0] OpData   = 2'd1;
  localparam logic [1:0] OpReseed = 2'd2;

  // PRINCE S-box written out from its definition, indexed by the input nibble.
  localparam logic [3:0] SboxTable [16] = '{
    4'hB, 4'hF, 4'h3, 4'h2, 4'hA, 4'hC, 4'h9, 4'h1,
    4'h6, 4'h7, 4'h8, 4'h0, 4'hE, 4'h5, 4'hD, 4'h4
  };

  // One row of stimulus together with the flags that it should produce.
  typedef struct packed {
    logic [1:0]                          op;
    logic                                data_req;
    logic                                exp_data_ack;
    logic                                exp_entropy_req;
    logic [3:0]                          max_stall;
    logic [NumBeats-1:0][BeatWidth-1:0]  beat;
  } row_t;

  logic           clk_i;
  logic           rst_ni;
  logic           data_req_i;
  logic           data_ack_o;
  clearing_data_t data_o;
  logic           reseed_req_i;
  logic           reseed_ack_o;
  logic           entropy_req_o;
  entropy_rsp_t   entropy_i;

  row_t                 rows [NumRows];
  logic [PrngWidth-1:0] model_state;

  prng_clearing_top uut (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .data_req_i    (data_req_i),
    .data_ack_o    (data_ack_o),
    .data_o        (data_o),
    .reseed_req_i  (reseed_req_i),
    .reseed_ack_o  (reseed_ack_o),
    .entropy_req_o (entropy_req_o),
    .entropy_i     (entropy_i)
  );

  // 20 ns clock period.
  always #10 clk_i = ~clk_i;

  // Generic bit permutation, output bit i takes input bit (mul*i+add) mod 64.
  function automatic logic [PrngWidth-1:0] permute(input logic [PrngWidth-1:0] word,
                                                   input int unsigned mul,
                                                   input int unsigned add);
    logic [PrngWidth-1:0] res;
    for (int unsigned i = 0; i < PrngWidth; i++) begin
      res[i] = word[(mul * i + add) % PrngWidth];
    end
    return res;
  endfunction

  // Expected first share: permute, substitute every nibble, permute again.
  function automatic logic [PrngWidth-1:0] mix_state(input logic [PrngWidth-1:0] state);
    logic [PrngWidth-1:0] perm;
    logic [PrngWidth-1:0] subst;
    perm = permute(state, 9, 0);
    for (int unsigned n = 0; n < PrngWidth / 4; n++) begin
      subst[4*n +: 4] = SboxTable[perm[4*n +: 4]];
    end
    return permute(subst, 9, 0);
  endfunction

  // One right-shifting Galois step.
  function automatic logic [PrngWidth-1:0] galois_step(input logic [PrngWidth-1:0] state);
    return state[0] ? ((state >> 1) ^ LfsrTaps) : (state >> 1);
  endfunction

  // The lowest beat lands in the lowest bits of the new seed.
  function automatic logic [PrngWidth-1:0] seed_from_beats(input row_t row);
    logic [PrngWidth-1:0] seed;
    for (int unsigned k = 0; k < NumBeats; k++) begin
      seed[k*BeatWidth +: BeatWidth] = row.beat[k];
    end
    return seed;
  endfunction

  // Builds a row. Beat values are random, an all-zero seed would lock up the LFSR.
  function automatic row_t make_row(input logic [1:0] op, input logic data_req,
                                    input logic exp_data_ack, input logic exp_entropy_req,
                                    input logic [3:0] max_stall);
    row_t row;
    row.op              = op;
    row.data_req        = data_req;
    row.exp_data_ack    = exp_data_ack;
    row.exp_entropy_req = exp_entropy_req;
    row.max_stall       = max_stall;
    for (int unsigned k = 0; k < NumBeats; k++) begin
      row.beat[k] = BeatWidth'($urandom());
    end
    if (row.beat == '0) begin
      row.beat[0] = BeatWidth'(1);
    end
    return row;
  endfunction

  task automatic compare_data(input string name, input clearing_data_t actual,
                              input clearing_data_t expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
      $display("tests failed");
      $fatal(1, "Mismatch on %s.", name);
    end
  endtask

  task automatic compare_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
      $display("tests failed");
      $fatal(1, "Mismatch on %s.", name);
    end
  endtask

  task automatic compare_state(input string name, input logic [PrngWidth-1:0] actual,
                               input logic [PrngWidth-1:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
      $display("tests failed");
      $fatal(1, "Mismatch on %s.", name);
    end
  endtask

  // Drives the inputs 2 ns after the rising edge and returns at the falling edge,
  // where all combinational outputs have settled.
  task automatic drive_inputs(input logic data_req, input logic reseed_req,
                              input logic ent_ack, input logic [BeatWidth-1:0] ent_data);
    @(posedge clk_i);
    #2;
    data_req_i     = data_req;
    reseed_req_i   = reseed_req;
    entropy_i.ack  = ent_ack;
    entropy_i.data = ent_data;
    @(negedge clk_i);
  endtask

  // Checks the handshake flags and both shares in the current cycle.
  task automatic check_cycle(input logic exp_data_ack, input logic exp_reseed_ack,
                             input logic exp_entropy_req);
    clearing_data_t expected;
    compare_flag("data_ack_o", data_ack_o, exp_data_ack);
    compare_flag("reseed_ack_o", reseed_ack_o, exp_reseed_ack);
    compare_flag("entropy_req_o", entropy_req_o, exp_entropy_req);
    compare_state("data_o.share0", data_o.share0, mix_state(model_state));
    // Both shares follow from the model state. Share1 is the (25*i+7) reordering of share0.
    expected.share0 = mix_state(model_state);
    expected.share1 = permute(expected.share0, 25, 7);
    compare_data("data_o", data_o, expected);
  endtask

  // A reseed row. Each beat may be preceded by a random number of stall cycles,
  // and only the final beat raises the reseed acknowledge.
  task automatic run_reseed(input row_t row);
    int unsigned gap;
    for (int unsigned k = 0; k < NumBeats; k++) begin
      gap = $urandom() % (int'(row.max_stall) + 1);
      repeat (gap) begin
        drive_inputs(row.data_req, 1'b1, 1'b0, BeatWidth'($urandom()));
        check_cycle(row.exp_data_ack, 1'b0, row.exp_entropy_req);
      end
      drive_inputs(row.data_req, 1'b1, 1'b1, row.beat[k]);
      check_cycle(row.exp_data_ack, k == NumBeats - 1, row.exp_entropy_req);
    end
    // The seed is loaded at the edge that ends the final beat.
    model_state = seed_from_beats(row);
  endtask

  initial begin
    void'($urandom(57283));
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    data_req_i   = 1'b0;
    reseed_req_i = 1'b0;
    entropy_i    = '0;
    model_state  = LfsrSeedDefault;

    // Reseed rows keep data_req high to show that reseeding wins.
    rows[0]  = make_row(OpIdle,   1'b0, 1'b0, 1'b0, 4'd0);
    rows[1]  = make_row(OpData,   1'b1, 1'b1, 1'b0, 4'd0);
    rows[2]  = make_row(OpData,   1'b1, 1'b1, 1'b0, 4'd0);
    rows[3]  = make_row(OpData,   1'b1, 1'b1, 1'b0, 4'd0);
    rows[4]  = make_row(OpIdle,   1'b0, 1'b0, 1'b0, 4'd0);
    rows[5]  = make_row(OpIdle,   1'b0, 1'b0, 1'b0, 4'd0);
    rows[6]  = make_row(OpData,   1'b1, 1'b1, 1'b0, 4'd0);
    rows[7]  = make_row(OpReseed, 1'b1, 1'b0, 1'b1, 4'd3);
    rows[8]  = make_row(OpIdle,   1'b0, 1'b0, 1'b0, 4'd0);
    rows[9]  = make_row(OpData,   1'b1, 1'b1, 1'b0, 4'd0);
    rows[10] = make_row(OpData,   1'b1, 1'b1, 1'b0, 4'd0);
    rows[11] = make_row(OpReseed, 1'b1, 1'b0, 1'b1, 4'd0);
    rows[12] = make_row(OpData,   1'b1, 1'b1, 1'b0, 4'd0);
    rows[13] = make_row(OpIdle,   1'b0, 1'b0, 1'b0, 4'd0);
    rows[14] = make_row(OpData,   1'b1, 1'b1, 1'b0, 4'd0);
    rows[15] = make_row(OpReseed, 1'b0, 1'b0, 1'b1, 4'd4);
    rows[16] = make_row(OpData,   1'b1, 1'b1, 1'b0, 4'd0);
    rows[17] = make_row(OpData,   1'b1, 1'b1, 1'b0, 4'd0);
    rows[18] = make_row(OpData,   1'b1, 1'b1, 1'b0, 4'd0);
    rows[19] = make_row(OpIdle,   1'b0, 1'b0, 1'b0, 4'd0);

    repeat (5) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    for (int unsigned r = 0; r < NumRows; r++) begin
      case (rows[r].op)
        OpData: begin
          drive_inputs(1'b1, 1'b0, 1'b0, '0);
          check_cycle(rows[r].exp_data_ack, 1'b0, rows[r].exp_entropy_req);
          // The value shown was consumed, the LFSR steps at the next edge.
          model_state = galois_step(model_state);
        end
        OpReseed: begin
          run_reseed(rows[r]);
        end
        default: begin
          drive_inputs(1'b0, 1'b0, 1'b0, '0);
          check_cycle(rows[r].exp_data_ack, 1'b0, rows[r].exp_entropy_req);
        end
      endcase
    end

    $display("all tests passed");
    $finish;
  end

  // Watchdog. A reseed row takes at most ten cycles, the budget covers the table easily.
  initial begin
    repeat (NumRows * 8 + 50) @(posedge clk_i);
    $display("Timeout: the test sequence did not finish in the expected number of cycles.");
    $display("tests failed");
    $fatal(1, "Watchdog expired.");
  end

endmodule

//--- src.f
verilog/prng_pkg.sv
verilog/prng_ctrl.sv
verilog/entropy_packer.sv
verilog/clearing_lfsr.sv
verilog/share_mixer.sv
verilog/prng_clearing_top.sv
verification/prng_clearing_tb.sv

//--- Makefile
# Verilator build and run for the clearing PRNG testbench.
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= prng_clearing_tb
FILELIST ?= src.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SRCS     := $(shell grep -v '^+' $(FILELIST))
PASS_MSG := all tests passed

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the pass message shows up in the output.
run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
